// ==== sms_host_top.f ====
logic/sms_host_pkg.sv
logic/clock_enable_gen.sv
logic/rom_loader.sv
logic/cheat_code_loader.sv
logic/backup_ram_sequencer.sv
logic/sms_host_top.sv
bench/sms_host_tb.sv

// ==== Bender.yml ====
package:
  name: sms_host

sources:
  - logic/sms_host_pkg.sv
  - logic/clock_enable_gen.sv
  - logic/rom_loader.sv
  - logic/cheat_code_loader.sv
  - logic/backup_ram_sequencer.sv
  - logic/sms_host_top.sv
  - target: test
    files:
      - bench/sms_host_tb.sv

// ==== bench/sms_host_tb.sv ====
/* Host glue testbench
   Models ROM memory and the backup card, runs downloads and backup jobs */
`timescale 1ns/10ps

module sms_host_tb
	import sms_host_pkg::*;
();

	localparam int BACKUP_SECTORS = 64;
	localparam int CART_BYTES     = 4096;
	localparam int WAIT_LIMIT     = 50;   // Cycles per handshake wait

	logic           clk_sys;
	logic           reset;
	ioctl_bus_t     ioctl;
	logic           ioctl_wait;
	rom_waddr_t     rom_waddr;
	byte_t          rom_wdata;
	logic           rom_wr_toggle;
	logic           rom_wr_ack;
	rom_addr_t      core_rom_addr;
	rom_addr_t      rom_raddr;
	logic           img_mounted, img_readonly, img_size_nonzero;
	logic           osd_open, load_cmd, save_cmd, autosave, nvram_we;
	sd_req_t        sd;
	logic           sd_ack;
	clock_enables_t ce;
	logic           handheld;
	cheat_code_t    code;
	logic           code_valid, cheat_reset, core_reset, activity_led;

	logic [31:0] lcg_state = 32'h2b49_a7a9;
	int          error_count = 0;
	int          errors_at_start = 0;
	int          tests_passed = 0;
	int          tests_failed = 0;
	int          valid_pulses = 0;
	int          cheat_reset_pulses = 0;
	string       cur_test = "reset";
	rom_waddr_t  wr_addr_q[$];       // Writes seen by the memory
	byte_t       wr_data_q[$];
	sd_lba_t     sd_lba_q[$];        // Sector requests seen by the card
	logic        sd_write_q[$];

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	sms_host_top #(
		.BACKUP_SECTORS (BACKUP_SECTORS)
	) u_dut (.*);

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Multiplicative hash so every address bit counts
	function automatic byte_t pattern_byte(input int unsigned a);
		return byte_t'((a * 32'd2654435761) >> 24);
	endfunction

	// ====================================================================
	// Memory and card models
	// ====================================================================
	initial begin : rom_memory
		int delay;
		rom_wr_ack = 1'b0;
		forever begin
			@(posedge clk_sys);
			if (!reset && (rom_wr_toggle !== rom_wr_ack)) begin
				wr_addr_q.push_back(rom_waddr);
				wr_data_q.push_back(rom_wdata);
				delay = (lcg_next() >> 16) % 6;
				repeat (delay) @(posedge clk_sys);
				rom_wr_ack <= rom_wr_toggle;  // Write done
			end
		end
	end

	initial begin : sd_card
		int delay;
		sd_ack = 1'b0;
		forever begin
			@(posedge clk_sys);
			if (!reset && (sd.rd || sd.wr)) begin
				sd_lba_q.push_back(sd.lba);
				sd_write_q.push_back(sd.wr);
				delay = 2 + (lcg_next() >> 16) % 5;
				repeat (delay) @(posedge clk_sys);
				sd_ack <= 1'b1;
				repeat (3) @(posedge clk_sys);
				sd_ack <= 1'b0;   // Sector transferred
			end
		end
	end

	// Back-pressure and pulse monitor
	always @(posedge clk_sys) begin
		if (!reset) begin
			assert (!(ioctl.wr && ioctl_wait)) else begin
				error_count++;
				$display("%s: a byte was strobed while ioctl_wait was high", cur_test);
			end
			if (code_valid)
				valid_pulses++;
			if (cheat_reset)
				cheat_reset_pulses++;
		end
	end

	// ====================================================================
	// Helpers
	// ====================================================================
	task automatic start_test(input string name);
		cur_test = name;
		errors_at_start = error_count;
	endtask

	task automatic close_test();
		if (error_count == errors_at_start) begin
			tests_passed++;
			$display("test %s: ok", cur_test);
		end else begin
			tests_failed++;
			$display("test %s: %0d checks failed", cur_test, error_count - errors_at_start);
		end
	endtask

	task automatic expect_equal(input string what, input logic [127:0] expected,
			input logic [127:0] actual);
		assert (actual === expected) else begin
			error_count++;
			$display("[FAIL] %s %s: expected %0h, actual %0h", cur_test, what, expected, actual);
		end
	endtask

	task automatic abort_on_timeout(input string what);
		$display("%s: timed out waiting for %s", cur_test, what);
		$display("sim failed");
		$finish;
	endtask

	task automatic wait_write_idle();
		int cycles;
		cycles = 0;
		@(posedge clk_sys);
		while (ioctl_wait) begin
			cycles++;
			if (cycles > WAIT_LIMIT)
				abort_on_timeout("ioctl_wait to fall");
			@(posedge clk_sys);
		end
	endtask

	task automatic begin_download(input file_index_t index);
		@(posedge clk_sys);
		ioctl.index    <= index;
		ioctl.addr     <= '0;
		ioctl.download <= 1'b1;
		repeat (2) @(posedge clk_sys);
	endtask

	task automatic send_byte(input int unsigned addr, input byte_t data);
		wait_write_idle();
		ioctl.addr <= ioctl_addr_t'(addr);
		ioctl.data <= data;
		ioctl.wr   <= 1'b1;
		@(posedge clk_sys);
		ioctl.wr <= 1'b0;
	endtask

	// Source leaves the byte count on the address bus
	task automatic end_download(input int n_bytes);
		wait_write_idle();
		ioctl.download <= 1'b0;
		ioctl.addr     <= ioctl_addr_t'(n_bytes);
		@(posedge clk_sys);
	endtask

	task automatic load_cart(input file_index_t index, input int n_bytes);
		int i;
		wr_addr_q.delete();
		wr_data_q.delete();
		begin_download(index);
		expect_equal("core_reset in download", 1, core_reset);
		expect_equal("activity_led in download", 1, activity_led);
		for (i = 0; i < n_bytes; i++)
			send_byte(i, pattern_byte(i));
		end_download(n_bytes);
	endtask

	task automatic wait_busy_level(input logic level, input int limit, input logic hold_reset);
		int cycles;
		cycles = 0;
		@(posedge clk_sys);
		while (u_dut.busy !== level) begin
			if (hold_reset)
				expect_equal("core_reset during job", 1, core_reset);
			if (!level)
				expect_equal("activity_led during job", 1, activity_led);
			cycles++;
			if (cycles > limit)
				abort_on_timeout("the busy flag");
			@(posedge clk_sys);
		end
	endtask

	task automatic check_mapping(input logic with_header);
		int        i;
		rom_addr_t a;
		rom_addr_t expected;
		for (i = 0; i < 8; i++) begin
			a = rom_addr_t'(lcg_next());
			@(posedge clk_sys);
			core_rom_addr <= a;
			@(posedge clk_sys);
			expected = with_header ? ((a + 22'd512) & 22'd4095) : (a & 22'd4095);
			expect_equal("rom_raddr", expected, rom_raddr);
		end
	endtask

	task automatic check_sectors(input logic is_write);
		int i;
		expect_equal("sector count", BACKUP_SECTORS, sd_lba_q.size());
		for (i = 0; i < sd_lba_q.size(); i++) begin
			if (sd_lba_q[i] !== sd_lba_t'(i) || sd_write_q[i] !== is_write) begin
				expect_equal($sformatf("sector %0d lba", i), i, sd_lba_q[i]);
				expect_equal($sformatf("sector %0d write", i), is_write, sd_write_q[i]);
				break;
			end
		end
	endtask

	// ====================================================================
	// Stimulus
	// ====================================================================
	initial begin : stimulus
		int          i;
		int          tally [2][4];    // Window by cpu, vdp, pix, sp
		int          last_pix;
		int          valid_start;
		int          reset_start;
		byte_t       cheat_bytes [16];
		cheat_word_t words [4];
		cheat_code_t expected_code;

		reset            = 1'b1;
		ioctl            = '0;
		core_rom_addr    = '0;
		img_mounted      = 1'b0;
		img_readonly     = 1'b0;
		img_size_nonzero = 1'b0;
		osd_open         = 1'b0;
		load_cmd         = 1'b0;
		save_cmd         = 1'b0;
		autosave         = 1'b0;
		nvram_we         = 1'b0;
		repeat (16) @(posedge clk_sys);
		reset <= 1'b0;
		repeat (4) @(posedge clk_sys);

		start_test("clock_enables");
		tally = '{default: 0};
		last_pix = -1;
		for (i = 0; i < 60; i++) begin
			@(posedge clk_sys);
			tally[i / 30][0] += ce.cpu;
			tally[i / 30][1] += ce.vdp;
			tally[i / 30][2] += ce.pix;
			tally[i / 30][3] += ce.sp;
			if (ce.pix) begin
				if (last_pix >= 0)
					expect_equal("pix spacing", 10, i - last_pix);
				last_pix = i;
			end
		end
		for (i = 0; i < 2; i++) begin
			expect_equal($sformatf("cpu window %0d", i), 2, tally[i][0]);
			expect_equal($sformatf("vdp window %0d", i), 6, tally[i][1]);
			expect_equal($sformatf("pix window %0d", i), 3, tally[i][2]);
			expect_equal($sformatf("sp window %0d", i), 15, tally[i][3]);
		end
		close_test();

		start_test("cart_write");
		load_cart(8'd0, CART_BYTES);
		expect_equal("write count", CART_BYTES, wr_addr_q.size());
		for (i = 0; i < wr_addr_q.size(); i++) begin
			if (wr_addr_q[i] !== rom_waddr_t'(i) || wr_data_q[i] !== pattern_byte(i)) begin
				expect_equal($sformatf("write %0d address", i), i, wr_addr_q[i]);
				expect_equal($sformatf("write %0d data", i), pattern_byte(i), wr_data_q[i]);
				break;
			end
		end
		close_test();

		// Plain image still loaded from the previous test
		start_test("rom_mapping");
		check_mapping(1'b0);
		expect_equal("handheld plain cart", 0, handheld);
		load_cart(8'd2, CART_BYTES + 512);
		expect_equal("restart address", 0, wr_addr_q[0]);
		repeat (2) @(posedge clk_sys);
		check_mapping(1'b1);
		expect_equal("handheld", 1, handheld);
		close_test();

		start_test("cheat_code");
		valid_start = valid_pulses;
		reset_start = cheat_reset_pulses;
		begin_download(CHEAT_INDEX);
		for (i = 0; i < 16; i++) begin
			cheat_bytes[i] = byte_t'(lcg_next() >> 24);
			send_byte(i, cheat_bytes[i]);
		end
		end_download(16);
		repeat (2) @(posedge clk_sys);
		words = '{default: '0};
		for (i = 0; i < 16; i++)
			words[i / 4][8 * (i % 4) +: 8] = cheat_bytes[i];
		expected_code.flags   = words[0];
		expected_code.address = words[1];
		expected_code.compare = words[2];
		expected_code.replace = words[3];
		expect_equal("code", expected_code, code);
		expect_equal("code_valid pulses", 1, valid_pulses - valid_start);
		expect_equal("cheat_reset pulses", 1, cheat_reset_pulses - reset_start);
		close_test();

		start_test("backup_load");
		img_mounted      <= 1'b1;
		img_readonly     <= 1'b0;
		img_size_nonzero <= 1'b1;
		sd_lba_q.delete();
		sd_write_q.delete();
		load_cart(8'd0, 1024);
		wait_busy_level(1'b1, 20, 1'b0);
		wait_busy_level(1'b0, BACKUP_SECTORS * 20, 1'b1);
		expect_equal("core_reset after load", 0, core_reset);
		expect_equal("activity_led after load", 0, activity_led);
		check_sectors(1'b0);
		close_test();

		start_test("backup_autosave");
		sd_lba_q.delete();
		sd_write_q.delete();
		@(posedge clk_sys);
		nvram_we <= 1'b1;   // Menu closed
		@(posedge clk_sys);
		nvram_we <= 1'b0;
		repeat (2) @(posedge clk_sys);
		expect_equal("pending after nvram write", 1, u_dut.pending);
		expect_equal("activity_led without autosave", 0, activity_led);
		autosave <= 1'b1;
		@(posedge clk_sys);
		expect_equal("activity_led with pending save", 1, activity_led);
		osd_open <= 1'b1;
		wait_busy_level(1'b1, 20, 1'b0);
		wait_busy_level(1'b0, BACKUP_SECTORS * 20, 1'b0);
		@(posedge clk_sys);
		expect_equal("pending after save", 0, u_dut.pending);
		expect_equal("busy after save", 0, u_dut.busy);
		check_sectors(1'b1);
		osd_open <= 1'b0;
		autosave <= 1'b0;
		close_test();

		$display("tests passed %0d, tests failed %0d, failed checks %0d",
			tests_passed, tests_failed, error_count);
		if (error_count == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

// ==== logic/sms_host_top.sv ====
/* Console host glue top level
   Joins the enable divider, cartridge and cheat loaders and backup sequencer */
`timescale 1ns/10ps

module sms_host_top
	import sms_host_pkg::*;
#(
	parameter int BACKUP_SECTORS = 64
) (
	input  logic           clk_sys,
	input  logic           reset,
	input  ioctl_bus_t     ioctl,
	output logic           ioctl_wait,

	// ROM memory
	output rom_waddr_t     rom_waddr,
	output byte_t          rom_wdata,
	output logic           rom_wr_toggle,
	input  logic           rom_wr_ack,
	input  rom_addr_t      core_rom_addr,
	output rom_addr_t      rom_raddr,

	// Backup card and commands
	input  logic           img_mounted,
	input  logic           img_readonly,
	input  logic           img_size_nonzero,
	input  logic           osd_open,
	input  logic           load_cmd,
	input  logic           save_cmd,
	input  logic           autosave,
	input  logic           nvram_we,
	output sd_req_t        sd,
	input  logic           sd_ack,

	// Core side
	output clock_enables_t ce,
	output logic           handheld,
	output cheat_code_t    code,
	output logic           code_valid,
	output logic           cheat_reset,
	output logic           core_reset,
	output logic           activity_led
);

	logic busy;
	logic loading;
	logic pending;

	// Core held in reset while a cart or its backup loads
	assign core_reset   = reset | cart_active(ioctl) | loading;
	assign activity_led = cart_active(ioctl) | busy | (pending & autosave);

	// ====================================================================
	// Blocks
	// ====================================================================
	clock_enable_gen u_ce_gen (
		.clk_sys (clk_sys),
		.reset   (reset),
		.ce      (ce)
	);

	rom_loader u_rom_loader (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.ioctl         (ioctl),
		.ioctl_wait    (ioctl_wait),
		.rom_waddr     (rom_waddr),
		.rom_wdata     (rom_wdata),
		.rom_wr_toggle (rom_wr_toggle),
		.rom_wr_ack    (rom_wr_ack),
		.core_rom_addr (core_rom_addr),
		.rom_raddr     (rom_raddr),
		.handheld      (handheld)
	);

	cheat_code_loader u_cheat_loader (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.ioctl       (ioctl),
		.code        (code),
		.code_valid  (code_valid),
		.cheat_reset (cheat_reset)
	);

	backup_ram_sequencer #(
		.BACKUP_SECTORS (BACKUP_SECTORS)
	) u_backup (
		.clk_sys          (clk_sys),
		.reset            (reset),
		.ioctl            (ioctl),
		.img_mounted      (img_mounted),
		.img_readonly     (img_readonly),
		.img_size_nonzero (img_size_nonzero),
		.osd_open         (osd_open),
		.load_cmd         (load_cmd),
		.save_cmd         (save_cmd),
		.autosave         (autosave),
		.nvram_we         (nvram_we),
		.sd               (sd),
		.sd_ack           (sd_ack),
		.busy             (busy),
		.loading          (loading),
		.pending          (pending)
	);

endmodule

// ==== logic/backup_ram_sequencer.sv ====
/* Backup RAM sequencer
   Loads and saves the backup image sector by sector, with autosave */
`timescale 1ns/10ps

module backup_ram_sequencer
	import sms_host_pkg::*;
#(
	parameter int BACKUP_SECTORS = 64
) (
	input  logic       clk_sys,
	input  logic       reset,
	input  ioctl_bus_t ioctl,
	input  logic       img_mounted,
	input  logic       img_readonly,
	input  logic       img_size_nonzero,
	input  logic       osd_open,
	input  logic       load_cmd,
	input  logic       save_cmd,
	input  logic       autosave,
	input  logic       nvram_we,
	output sd_req_t    sd,
	input  logic       sd_ack,
	output logic       busy,
	output logic       loading,
	output logic       pending
);

	localparam sd_lba_t LAST_LBA = sd_lba_t'(BACKUP_SECTORS - 1);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LOADING,
		ST_SAVING
	} bk_state_t;

	bk_state_t state;
	logic      cart_download;
	logic      dl_prev;
	logic      enable;
	logic      save_req;
	logic      load_en;
	logic      save_en;
	logic      load_prev;
	logic      save_prev;
	logic      ack_prev;
	logic      start_load;
	logic      start_save;

	assign cart_download = cart_active(ioctl);
	assign save_req      = save_cmd | (pending & osd_open & autosave);
	assign load_en       = load_cmd & enable;
	assign save_en       = save_req & enable;

	assign start_load = (load_en & ~load_prev) | (dl_prev & ~cart_download & img_size_nonzero);
	assign start_save = save_en & ~save_prev;

	assign busy    = (state != ST_IDLE);
	assign loading = (state == ST_LOADING);

	// ====================================================================
	// Enable and pending save
	// ====================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_prev <= 1'b0;
			enable  <= 1'b0;
			pending <= 1'b0;
		end else begin
			dl_prev <= cart_download;
			if (cart_download & ~dl_prev)
				enable <= 1'b0;
			// Image mounts while the cart is still downloading
			if (cart_download & img_mounted & ~img_readonly)
				enable <= 1'b1;

			if (nvram_we & ~osd_open)
				pending <= 1'b1;
			else if (busy)
				pending <= 1'b0;
		end
	end

	// ====================================================================
	// Sector FSM
	// ====================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state     <= ST_IDLE;
			sd        <= '0;
			load_prev <= 1'b0;
			save_prev <= 1'b0;
			ack_prev  <= 1'b0;
		end else begin
			load_prev <= load_en;
			save_prev <= save_en;
			ack_prev  <= sd_ack;

			if (sd_ack & ~ack_prev) begin
				sd.rd <= 1'b0;  // Card took the request
				sd.wr <= 1'b0;
			end

			case (state)
				ST_IDLE: begin
					if (start_load | start_save) begin
						state  <= start_load ? ST_LOADING : ST_SAVING;
						sd.lba <= '0;
						sd.rd  <= start_load;
						sd.wr  <= ~start_load;
					end
				end
				ST_LOADING, ST_SAVING: begin
					if (ack_prev & ~sd_ack) begin  // Sector done
						if (sd.lba == LAST_LBA) begin
							state <= ST_IDLE;
						end else begin
							sd.lba <= sd.lba + 1'b1;
							sd.rd  <= (state == ST_LOADING);
							sd.wr  <= (state == ST_SAVING);
						end
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

// ==== logic/cheat_code_loader.sv ====
/* Cheat code loader
   Packs 16 downloaded bytes into one code and strobes it out */
`timescale 1ns/10ps

module cheat_code_loader
	import sms_host_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  ioctl_bus_t  ioctl,
	output cheat_code_t code,
	output logic        code_valid,
	output logic        cheat_reset
);

	logic       code_strobe;
	logic [1:0] byte_sel;
	logic [4:0] bit_base;

	assign code_strobe = ioctl.wr & cheat_active(ioctl);
	assign byte_sel    = ioctl.addr[1:0];
	assign bit_base    = {byte_sel, 3'b000};  // Byte k at bit 8k

	// Field picked by address bits 3:2
	always_ff @(posedge clk_sys) begin
		if (code_strobe) begin
			case (ioctl.addr[3:2])
				2'd0: code.flags[bit_base +: 8]   <= ioctl.data;
				2'd1: code.address[bit_base +: 8] <= ioctl.data;
				2'd2: code.compare[bit_base +: 8] <= ioctl.data;
				2'd3: code.replace[bit_base +: 8] <= ioctl.data;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			code_valid  <= 1'b0;
			cheat_reset <= 1'b0;
		end else begin
			code_valid  <= code_strobe & (ioctl.addr[3:0] == 4'hf);  // Last byte
			// Any new download flushes the stored codes
			cheat_reset <= ioctl.download & ioctl.wr & (ioctl.addr == '0);
		end
	end

endmodule

// ==== logic/rom_loader.sv ====
/* Cartridge loader
   Writes downloaded bytes to ROM memory, sizes the image and maps core reads */
`timescale 1ns/10ps

module rom_loader
	import sms_host_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	input  ioctl_bus_t ioctl,
	output logic       ioctl_wait,
	output rom_waddr_t rom_waddr,
	output byte_t      rom_wdata,
	output logic       rom_wr_toggle,
	input  logic       rom_wr_ack,
	input  rom_addr_t  core_rom_addr,
	output rom_addr_t  rom_raddr,
	output logic       handheld
);

	logic      cart_download;
	logic      dl_prev;
	logic      byte_strobe;
	rom_addr_t byte_addr;
	rom_addr_t cart_mask;
	rom_addr_t mask512;
	logic      header_present;

	assign cart_download = cart_active(ioctl);
	assign byte_strobe   = ioctl.wr & cart_download;
	assign byte_addr     = rom_addr_t'(ioctl.addr);

	// ====================================================================
	// Write handshake
	// ====================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_prev       <= 1'b0;
			ioctl_wait    <= 1'b0;
			rom_wr_toggle <= 1'b0;
			rom_waddr     <= '0;
		end else begin
			dl_prev <= cart_download;
			if (cart_download & ~dl_prev) begin
				rom_waddr <= '0;  // New image
			end else if (byte_strobe) begin
				ioctl_wait    <= 1'b1;
				rom_wr_toggle <= ~rom_wr_toggle;  // Request one write
			end else if (ioctl_wait && (rom_wr_toggle == rom_wr_ack)) begin
				ioctl_wait <= 1'b0;
				rom_waddr  <= rom_waddr + 1'b1;
			end
		end
	end

	// Data held for the memory until the next byte
	always_ff @(posedge clk_sys) begin
		if (byte_strobe)
			rom_wdata <= ioctl.data;
	end

	// ====================================================================
	// Image sizing
	// ====================================================================

	// Masks grow as the OR of all offsets seen
	always_ff @(posedge clk_sys) begin
		if (byte_strobe) begin
			if (ioctl.addr == '0)
				cart_mask <= '0;
			else
				cart_mask <= cart_mask | byte_addr;

			if (ioctl.addr == ioctl_addr_t'(HEADER_BYTES))
				mask512 <= '0;
			else
				mask512 <= mask512 | (byte_addr - rom_addr_t'(HEADER_BYTES));
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			header_present <= 1'b0;
			handheld       <= 1'b0;
		end else begin
			if (byte_strobe)
				handheld <= (ioctl.index[4:0] == GG_INDEX);
			// Address now holds the byte count, odd 512 block means header
			if (dl_prev & ~cart_download)
				header_present <= ioctl.addr[9];
		end
	end

	// Core reads skip the header and wrap within the image
	always_comb begin
		if (header_present)
			rom_raddr = (core_rom_addr + rom_addr_t'(HEADER_BYTES)) & mask512;
		else
			rom_raddr = core_rom_addr & cart_mask;
	end

endmodule

// ==== logic/clock_enable_gen.sv ====
/* Clock enable divider
   Derives the CPU, video, pixel and sound strobes from one 30-cycle sequence */
`timescale 1ns/10ps

module clock_enable_gen
	import sms_host_pkg::*;
(
	input  logic           clk_sys,
	input  logic           reset,
	output clock_enables_t ce
);

	localparam int CNT_W = $clog2(CE_PERIOD);

	logic [CNT_W-1:0] count;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			count <= '0;
			ce    <= '0;
		end else begin
			count <= (count == CNT_W'(CE_PERIOD - 1)) ? '0 : count + 1'b1;

			ce.sp  <= count[0];  // Half rate
			ce.vdp <= 1'b0;
			ce.pix <= 1'b0;
			ce.cpu <= 1'b0;

			// Video every 5, pixel every 10, CPU every 15
			case (count)
				4, 14: ce.vdp <= 1'b1;
				9: begin
					ce.cpu <= 1'b1;
					ce.vdp <= 1'b1;
					ce.pix <= 1'b1;
				end
				19: begin
					ce.vdp <= 1'b1;
					ce.pix <= 1'b1;
				end
				24: begin
					ce.cpu <= 1'b1;  // Late CPU phase for the H counter
					ce.vdp <= 1'b1;
				end
				CE_PERIOD - 1: begin
					ce.vdp <= 1'b1;
					ce.pix <= 1'b1;
				end
				default: ;
			endcase
		end
	end

endmodule

// ==== logic/sms_host_pkg.sv ====
/* Console host glue shared definitions
   Bus widths, packed structs and constants used by all host blocks */
package sms_host_pkg;

	// ====================================================================
	// Widths
	// ====================================================================
	typedef logic [7:0]  byte_t;
	typedef logic [24:0] ioctl_addr_t;     // Offset within one download
	typedef logic [7:0]  file_index_t;
	typedef logic [21:0] rom_addr_t;       // Cartridge space, 4 MiB
	typedef logic [23:0] rom_waddr_t;
	typedef logic [31:0] sd_lba_t;
	typedef logic [31:0] cheat_word_t;

	// ====================================================================
	// Bundles
	// ====================================================================
	typedef struct packed {
		logic        wr;       // One strobe per byte
		ioctl_addr_t addr;
		byte_t       data;
		logic        download; // High for the whole transfer
		file_index_t index;
	} ioctl_bus_t;

	typedef struct packed {
		cheat_word_t flags;
		cheat_word_t address;
		cheat_word_t compare;
		cheat_word_t replace;
	} cheat_code_t;

	typedef struct packed {
		sd_lba_t lba;
		logic    rd;
		logic    wr;
	} sd_req_t;

	typedef struct packed {
		logic cpu;
		logic vdp;
		logic pix;
		logic sp;
	} clock_enables_t;

	localparam file_index_t CHEAT_INDEX  = '1;
	localparam logic [4:0]  GG_INDEX     = 5'd2; // Handheld cart slot
	localparam int          HEADER_BYTES = 512;  // Copier header
	localparam int          CE_PERIOD    = 30;

	// Download classification
	function automatic logic cheat_active(input ioctl_bus_t bus);
		return bus.download & (bus.index == CHEAT_INDEX);
	endfunction

	function automatic logic cart_active(input ioctl_bus_t bus);
		return bus.download & (bus.index != CHEAT_INDEX);
	endfunction

endpackage
